// File: hdl/squeeze_dims_pkg.sv
`default_nettype none

package squeeze_dims_pkg;

	localparam int lanes = 4; // output channels per beat.
	localparam int data_w = 16;
	localparam int wgt_w = 8;
	localparam int acc_w = 28;
	localparam int ofm_shift = 4;

	localparam int chin_fire8 = 12;
	localparam int chin_fire9 = 16;
	localparam int chin_max = (chin_fire8 > chin_fire9) ? chin_fire8 : chin_fire9;
	localparam int beat_w = $clog2(chin_max);

	// fire9 rows follow the fire8 region.
	localparam int fire9_base = chin_fire8;
	localparam int rom_depth = chin_fire8 + chin_fire9;
	localparam int rom_addr_w = $clog2(rom_depth);

	localparam logic signed [data_w-1:0] data_max = {1'b0, {(data_w - 1){1'b1}}};
	localparam logic signed [data_w-1:0] data_min = {1'b1, {(data_w - 1){1'b0}}};

	// synthetic weights, centred on zero.
	function automatic logic signed [wgt_w-1:0] weight_of(input int row, input int lane);
		return wgt_w'(((3 * row + 5 * lane + 1) % 16) - 8);
	endfunction

	function automatic logic signed [data_w-1:0] scale_ofm(input logic signed [acc_w-1:0] acc);
		logic signed [acc_w-1:0] shifted;
		shifted = acc >>> ofm_shift;
		if (shifted > acc_w'(data_max))
			return data_max;
		else if (shifted < acc_w'(data_min))
			return data_min;
		else
			return shifted[data_w-1:0];
	endfunction

endpackage

`default_nettype wire

// File: hdl/squeeze_ctrl_pkg.sv
`default_nettype none

package squeeze_ctrl_pkg;

	typedef enum logic [1:0] {
		IDLE,
		ACCUM,
		DRAIN, // last product still in the mac.
		HOLD
	} engine_state_e;

	typedef enum logic {
		FIRE8,
		FIRE9
	} layer_e;

endpackage

`default_nettype wire

// File: hdl/weight_bus_if.sv
`timescale 1ns/1ps
`default_nettype none

interface weight_bus_if ();

	logic req; // engine wants the rom.
	logic step; // one accepted beat.
	logic done;
	logic grant;
	logic [squeeze_dims_pkg::lanes*squeeze_dims_pkg::wgt_w-1:0] kernels;

	modport engine (
		output req,
		output step,
		output done,
		input grant,
		input kernels
	);

	modport sequencer (
		input req,
		input step,
		input done,
		output grant,
		output kernels
	);

endinterface

`default_nettype wire

// File: hdl/weight_rom.sv
`timescale 1ns/1ps
`default_nettype none

module weight_rom (
	input wire clk,
	input wire [squeeze_dims_pkg::rom_addr_w-1:0] addr_i,
	output logic [squeeze_dims_pkg::lanes*squeeze_dims_pkg::wgt_w-1:0] kernels_o
);

	localparam int lanes = squeeze_dims_pkg::lanes;
	localparam int wgt_w = squeeze_dims_pkg::wgt_w;
	localparam int rom_depth = squeeze_dims_pkg::rom_depth;

	logic [lanes*wgt_w-1:0] mem [rom_depth];

	initial begin
		for (int a = 0; a < rom_depth; a++) begin
			for (int l = 0; l < lanes; l++) begin
				mem[a][l*wgt_w +: wgt_w] = squeeze_dims_pkg::weight_of(a, l);
			end
		end
	end

	// address runs one past the last row after a fire9 frame.
	always_ff @(posedge clk) begin
		if (int'(addr_i) < rom_depth)
			kernels_o <= mem[addr_i];
		else
			kernels_o <= '0;
	end

endmodule

`default_nettype wire

// File: hdl/weight_addr_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module weight_addr_sequencer (
	input wire clk,
	input wire rst_n_i,
	weight_bus_if.sequencer fire8_bus,
	weight_bus_if.sequencer fire9_bus
);

	localparam int rom_addr_w = squeeze_dims_pkg::rom_addr_w;
	localparam int kern_w = squeeze_dims_pkg::lanes * squeeze_dims_pkg::wgt_w;

	logic busy;
	squeeze_ctrl_pkg::layer_e owner;
	logic [rom_addr_w-1:0] addr;
	logic [kern_w-1:0] rom_kernels;
	logic fire8_own;
	logic fire9_own;
	logic owner_step;
	logic owner_done;

	weight_rom u_rom (
		.clk(clk),
		.addr_i(addr),
		.kernels_o(rom_kernels)
	);

	assign fire8_own = busy && (owner == squeeze_ctrl_pkg::FIRE8);
	assign fire9_own = busy && (owner == squeeze_ctrl_pkg::FIRE9);

	assign owner_step = fire8_own ? fire8_bus.step : fire9_bus.step;
	assign owner_done = fire8_own ? fire8_bus.done : fire9_bus.done;

	// fire8 wins a tie, grant holds until done.
	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			busy <= 1'b0;
			owner <= squeeze_ctrl_pkg::FIRE8;
			addr <= '0;
		end else if (!busy) begin
			if (fire8_bus.req) begin
				busy <= 1'b1;
				owner <= squeeze_ctrl_pkg::FIRE8;
				addr <= '0;
			end else if (fire9_bus.req) begin
				busy <= 1'b1;
				owner <= squeeze_ctrl_pkg::FIRE9;
				addr <= rom_addr_w'(squeeze_dims_pkg::fire9_base);
			end
		end else if (owner_done) begin
			busy <= 1'b0;
		end else if (owner_step) begin
			addr <= addr + 1'b1; // next row lands one read later.
		end
	end

	assign fire8_bus.grant = fire8_own;
	assign fire9_bus.grant = fire9_own;

	assign fire8_bus.kernels = fire8_own ? rom_kernels : '0;
	assign fire9_bus.kernels = fire9_own ? rom_kernels : '0;

endmodule

`default_nettype wire

// File: hdl/squeeze_engine.sv
`timescale 1ns/1ps
`default_nettype none

module squeeze_engine #(
	parameter squeeze_ctrl_pkg::layer_e layer = squeeze_ctrl_pkg::FIRE8
) (
	input wire clk,
	input wire rst_n_i,
	input wire en_i,
	input wire [squeeze_dims_pkg::data_w-1:0] ifm_i,
	input wire ram_feedback_i,
	output logic sample_o,
	output logic finish_o,
	output logic [squeeze_dims_pkg::lanes*squeeze_dims_pkg::data_w-1:0] ofm_o,
	weight_bus_if.engine wbus
);

	localparam int lanes = squeeze_dims_pkg::lanes;
	localparam int data_w = squeeze_dims_pkg::data_w;
	localparam int wgt_w = squeeze_dims_pkg::wgt_w;
	localparam int acc_w = squeeze_dims_pkg::acc_w;
	localparam int beat_w = squeeze_dims_pkg::beat_w;
	localparam int chin = (layer == squeeze_ctrl_pkg::FIRE8) ?
		squeeze_dims_pkg::chin_fire8 : squeeze_dims_pkg::chin_fire9;
	localparam logic [beat_w-1:0] last_beat = beat_w'(chin - 1);

	squeeze_ctrl_pkg::engine_state_e state;
	logic [beat_w-1:0] beat_cnt;
	logic accept;
	logic mac_vld;
	logic signed [data_w-1:0] ifm_d;
	logic signed [wgt_w-1:0] kern [lanes];
	logic signed [acc_w-1:0] prod [lanes];
	logic signed [acc_w-1:0] acc [lanes];

	assign sample_o = (state == squeeze_ctrl_pkg::ACCUM);
	assign accept = en_i && sample_o;

	assign wbus.req = (state == squeeze_ctrl_pkg::IDLE) && en_i; // only with data waiting.
	assign wbus.step = accept;
	assign wbus.done = (state == squeeze_ctrl_pkg::DRAIN);

	always_comb begin
		for (int l = 0; l < lanes; l++) begin
			kern[l] = wbus.kernels[l*wgt_w +: wgt_w];
			prod[l] = acc_w'(ifm_d) * acc_w'(kern[l]);
		end
	end

	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			state <= squeeze_ctrl_pkg::IDLE;
			beat_cnt <= '0;
			finish_o <= 1'b0;
			ofm_o <= '0;
		end else begin
			case (state)
				squeeze_ctrl_pkg::IDLE: begin
					if (wbus.grant) begin
						state <= squeeze_ctrl_pkg::ACCUM;
						beat_cnt <= '0;
					end
				end
				squeeze_ctrl_pkg::ACCUM: begin
					if (accept) begin
						if (beat_cnt == last_beat)
							state <= squeeze_ctrl_pkg::DRAIN;
						else
							beat_cnt <= beat_cnt + 1'b1;
					end
				end
				squeeze_ctrl_pkg::DRAIN: begin
					state <= squeeze_ctrl_pkg::HOLD;
				end
				squeeze_ctrl_pkg::HOLD: begin
					if (!finish_o) begin
						finish_o <= 1'b1;
						for (int l = 0; l < lanes; l++) begin
							ofm_o[l*data_w +: data_w] <= squeeze_dims_pkg::scale_ofm(acc[l]);
						end
					end else if (ram_feedback_i) begin
						// downstream took the result.
						finish_o <= 1'b0;
						ofm_o <= '0;
						state <= squeeze_ctrl_pkg::IDLE;
					end
				end
				default: state <= squeeze_ctrl_pkg::IDLE;
			endcase
		end
	end

	// the row for a beat arrives one cycle after acceptance.
	always_ff @(posedge clk) begin
		if (accept)
			ifm_d <= ifm_i;
	end

	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			mac_vld <= 1'b0;
			for (int l = 0; l < lanes; l++) begin
				acc[l] <= '0;
			end
		end else begin
			mac_vld <= accept;
			if ((state == squeeze_ctrl_pkg::IDLE) && wbus.grant) begin
				for (int l = 0; l < lanes; l++) begin
					acc[l] <= '0; // new frame.
				end
			end else if (mac_vld) begin
				for (int l = 0; l < lanes; l++) begin
					acc[l] <= acc[l] + prod[l];
				end
			end
		end
	end

endmodule

`default_nettype wire

// File: hdl/squeeze_top.sv
`timescale 1ns/1ps
`default_nettype none

module squeeze_top (
	input wire clk,
	input wire rst_n_i,
	input wire fire8_en_i,
	input wire fire9_en_i,
	input wire [squeeze_dims_pkg::data_w-1:0] fire8_ifm_i,
	input wire [squeeze_dims_pkg::data_w-1:0] fire9_ifm_i,
	input wire fire8_ram_feedback_i,
	input wire fire9_ram_feedback_i,
	output logic fire8_sample_o,
	output logic fire9_sample_o,
	output logic fire8_finish_o,
	output logic fire9_finish_o,
	output logic [squeeze_dims_pkg::lanes*squeeze_dims_pkg::data_w-1:0] fire8_ofm_o,
	output logic [squeeze_dims_pkg::lanes*squeeze_dims_pkg::data_w-1:0] fire9_ofm_o
);

	localparam int data_w = squeeze_dims_pkg::data_w;

	logic fire8_en;
	logic fire9_en;
	logic [data_w-1:0] fire8_ifm;
	logic [data_w-1:0] fire9_ifm;

	// stage 1 input registers.
	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			fire8_en <= 1'b0;
			fire9_en <= 1'b0;
			fire8_ifm <= '0;
			fire9_ifm <= '0;
		end else begin
			fire8_en <= fire8_en_i;
			fire9_en <= fire9_en_i;
			fire8_ifm <= fire8_ifm_i;
			fire9_ifm <= fire9_ifm_i;
		end
	end

	weight_bus_if fire8_wbus ();
	weight_bus_if fire9_wbus ();

	squeeze_engine #(
		.layer(squeeze_ctrl_pkg::FIRE8)
	) u_fire8 (
		.clk(clk),
		.rst_n_i(rst_n_i),
		.en_i(fire8_en),
		.ifm_i(fire8_ifm),
		.ram_feedback_i(fire8_ram_feedback_i),
		.sample_o(fire8_sample_o),
		.finish_o(fire8_finish_o),
		.ofm_o(fire8_ofm_o),
		.wbus(fire8_wbus.engine)
	);

	squeeze_engine #(
		.layer(squeeze_ctrl_pkg::FIRE9)
	) u_fire9 (
		.clk(clk),
		.rst_n_i(rst_n_i),
		.en_i(fire9_en),
		.ifm_i(fire9_ifm),
		.ram_feedback_i(fire9_ram_feedback_i),
		.sample_o(fire9_sample_o),
		.finish_o(fire9_finish_o),
		.ofm_o(fire9_ofm_o),
		.wbus(fire9_wbus.engine)
	);

	// one rom, shared by both layers.
	weight_addr_sequencer u_seq (
		.clk(clk),
		.rst_n_i(rst_n_i),
		.fire8_bus(fire8_wbus.sequencer),
		.fire9_bus(fire9_wbus.sequencer)
	);

endmodule

`default_nettype wire

// File: verification/squeeze_tb.sv
`timescale 1ns/1ps
`default_nettype none

module squeeze_tb;

	localparam int lanes = squeeze_dims_pkg::lanes;
	localparam int data_w = squeeze_dims_pkg::data_w;
	localparam int chin_max = squeeze_dims_pkg::chin_max;
	localparam int ofm_w = lanes * data_w;
	localparam int total_frames = 23;
	localparam int watchdog_cycles = total_frames * (chin_max + 40);
	localparam logic signed [data_w-1:0] ifm_max = {1'b0, {(data_w - 1){1'b1}}};
	localparam logic signed [data_w-1:0] ifm_min = {1'b1, {(data_w - 1){1'b0}}};

	logic clk;
	logic rst_n;
	logic en [2]; // index 0 is fire8, 1 is fire9.
	logic [data_w-1:0] ifm [2];
	logic fb [2];
	logic sample [2];
	logic finish [2];
	logic [ofm_w-1:0] ofm [2];

	logic [ofm_w-1:0] expected [2][32];
	int last_acc [2][32]; // edge that took the last beat.
	int first_smp [2][32];
	int sent [2];
	int checked [2];
	int fb_delay [2];
	int cyc = 0;
	int n_pass = 0;
	int n_fail = 0;

	squeeze_top uut (
		.clk(clk), .rst_n_i(rst_n),
		.fire8_en_i(en[0]), .fire9_en_i(en[1]),
		.fire8_ifm_i(ifm[0]), .fire9_ifm_i(ifm[1]),
		.fire8_ram_feedback_i(fb[0]), .fire9_ram_feedback_i(fb[1]),
		.fire8_sample_o(sample[0]), .fire9_sample_o(sample[1]),
		.fire8_finish_o(finish[0]), .fire9_finish_o(finish[1]),
		.fire8_ofm_o(ofm[0]), .fire9_ofm_o(ofm[1])
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	always @(posedge clk) begin
		cyc <= cyc + 1;
	end

	function automatic int weight_rule(input int row, input int lane);
		return ((3 * row + 5 * lane + 1) % 16) - 8;
	endfunction

	function automatic logic [ofm_w-1:0] ref_frame(input int l,
			input logic signed [data_w-1:0] vals [chin_max]);
		logic [ofm_w-1:0] res;
		longint acc;
		int n;
		int base;
		n = (l == 1) ? squeeze_dims_pkg::chin_fire9 : squeeze_dims_pkg::chin_fire8;
		base = (l == 1) ? squeeze_dims_pkg::fire9_base : 0;
		res = '0;
		for (int k = 0; k < lanes; k++) begin
			acc = '0;
			for (int i = 0; i < n; i++) begin
				acc += longint'(vals[i]) * longint'(weight_rule(base + i, k));
			end
			acc = acc >>> squeeze_dims_pkg::ofm_shift; // rounds toward minus infinity.
			if (acc > longint'(ifm_max))
				acc = longint'(ifm_max);
			else if (acc < longint'(ifm_min))
				acc = longint'(ifm_min);
			res[k*data_w +: data_w] = acc[data_w-1:0];
		end
		return res;
	endfunction

	// mode 1 and 2 drive lane 0 into saturation, 3 mixes in extremes.
	function automatic logic signed [data_w-1:0] pick_ifm(input int l, input int i, input int mode);
		int w;
		int r;
		w = weight_rule(((l == 1) ? squeeze_dims_pkg::fire9_base : 0) + i, 0);
		r = int'($urandom % 4);
		case (mode)
			1: return (w >= 0) ? ifm_max : ifm_min;
			2: return (w >= 0) ? ifm_min : ifm_max;
			3: return (r == 0) ? ifm_max : ((r == 1) ? ifm_min : data_w'($urandom));
			default: return data_w'($urandom);
		endcase
	endfunction

	task automatic send_frame(input int l, input int mode, input bit gaps);
		logic signed [data_w-1:0] vals [chin_max];
		int n;
		int idx;
		int gap;
		n = (l == 1) ? squeeze_dims_pkg::chin_fire9 : squeeze_dims_pkg::chin_fire8;
		idx = sent[l];
		for (int i = 0; i < chin_max; i++) begin
			vals[i] = pick_ifm(l, i, mode);
		end
		expected[l][idx] = ref_frame(l, vals);
		sent[l] = idx + 1;
		for (int i = 0; i < n; i++) begin
			gap = gaps ? int'($urandom % 3) : 0;
			if (gap > 0)
				en[l] = 1'b0;
			repeat (gap) begin
				@(posedge clk);
				#2;
			end
			en[l] = 1'b1;
			ifm[l] = vals[i];
			// beat is in the input register, taken on the next edge once sample shows.
			do begin
				@(posedge clk);
				#2;
			end while (!sample[l]);
			if (i == 0)
				first_smp[l][idx] = cyc;
		end
		last_acc[l][idx] = cyc + 1;
		en[l] = 1'b0;
	endtask

	task automatic check_results(input int l);
		int idx;
		logic [ofm_w-1:0] held;
		logic [data_w-1:0] got;
		logic [data_w-1:0] want;
		forever begin
			@(posedge clk);
			#2;
			if (finish[l]) begin
				idx = checked[l];
				assert (cyc - last_acc[l][idx] == 2) n_pass++;
				else begin
					n_fail++;
					$display("Fail at %0t ns: fire%0d frame %0d finish %0d clocks after last beat",
						$time, 8 + l, idx, cyc - last_acc[l][idx]);
				end
				for (int k = 0; k < lanes; k++) begin
					got = ofm[l][k*data_w +: data_w];
					want = expected[l][idx][k*data_w +: data_w];
					assert (got == want) n_pass++;
					else begin
						n_fail++;
						$display("Fail at %0t ns: fire%0d frame %0d lane %0d ofm %0d, expected %0d",
							$time, 8 + l, idx, k, $signed(got), $signed(want));
					end
				end
				held = ofm[l];
				repeat (fb_delay[l]) begin
					@(posedge clk);
					#2;
					assert (finish[l] && ofm[l] == held && !sample[l]) n_pass++;
					else begin
						n_fail++;
						$display("Fail at %0t ns: fire%0d result not held while feedback low",
							$time, 8 + l);
					end
				end
				fb[l] = 1'b1;
				@(posedge clk);
				#2;
				fb[l] = 1'b0;
				assert (!finish[l]) n_pass++;
				else begin
					n_fail++;
					$display("Fail at %0t ns: fire%0d finish still high after feedback",
						$time, 8 + l);
				end
				checked[l] = idx + 1;
			end
		end
	endtask

	task automatic wait_results();
		while (checked[0] != sent[0] || checked[1] != sent[1]) begin
			@(posedge clk);
			#2;
		end
	endtask

	task automatic report_test(input string name, input int fails_before);
		if (n_fail == fails_before)
			$display("%s: ok", name);
		else
			$display("%s: %0d failed checks", name, n_fail - fails_before);
	endtask

	initial check_results(0);
	initial check_results(1);

	initial begin
		repeat (watchdog_cycles) @(posedge clk);
		$display("timeout: results still missing after %0d clocks", watchdog_cycles);
		$display("Simulation finished: FAIL");
		$finish;
	end

	initial begin
		int fails;
		void'($urandom(4));
		rst_n = 1'b0;
		for (int l = 0; l < 2; l++) begin
			en[l] = 1'b0;
			ifm[l] = '0;
			fb[l] = 1'b0;
			fb_delay[l] = 0;
		end
		repeat (4) @(posedge clk);
		#2;
		rst_n = 1'b1;

		fails = n_fail;
		repeat (4) begin
			@(posedge clk);
			#2;
			assert (!sample[0] && !sample[1] && !finish[0] && !finish[1]
				&& ofm[0] == '0 && ofm[1] == '0) n_pass++;
			else begin
				n_fail++;
				$display("Fail at %0t ns: outputs active after reset with no enable", $time);
			end
		end
		send_frame(0, 3, 1'b0);
		wait_results();
		report_test("test 1 reset and fire8 frame", fails);

		fails = n_fail;
		send_frame(1, 3, 1'b0);
		wait_results();
		report_test("test 2 fire9 frame at base offset", fails);

		// both layers ask at once, fire8 has priority.
		fails = n_fail;
		fork
			send_frame(0, 3, 1'b0);
			send_frame(1, 3, 1'b0);
		join
		wait_results();
		assert (first_smp[1][sent[1] - 1] > last_acc[0][sent[0] - 1]) n_pass++;
		else begin
			n_fail++;
			$display("fire9 was granted the rom before fire8 took all its beats");
		end
		report_test("test 3 shared rom arbitration", fails);

		fails = n_fail;
		fb_delay[0] = 5 + int'($urandom % 16);
		fork
			begin
				send_frame(0, 3, 1'b0);
				send_frame(0, 3, 1'b0);
			end
			send_frame(1, 3, 1'b0);
		join
		wait_results();
		report_test("test 4 back-pressure", fails);

		fails = n_fail;
		fb_delay[0] = int'($urandom % 4);
		fb_delay[1] = int'($urandom % 4);
		fork
			for (int f = 0; f < 8; f++) begin
				send_frame(0, f % 4, 1'b1);
			end
			for (int f = 0; f < 8; f++) begin
				send_frame(1, f % 4, 1'b1);
			end
		join
		wait_results();
		report_test("test 5 random frames with gaps", fails);

		$display("checks passed %0d, checks failed %0d", n_pass, n_fail);
		if (n_fail == 0)
			$display("Simulation finished: PASS");
		else
			$display("Simulation finished: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

// File: filelist.f
hdl/squeeze_dims_pkg.sv
hdl/squeeze_ctrl_pkg.sv
hdl/weight_bus_if.sv
hdl/weight_rom.sv
hdl/weight_addr_sequencer.sv
hdl/squeeze_engine.sv
hdl/squeeze_top.sv
verification/squeeze_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP ?= squeeze_tb
FILELIST ?= filelist.f
OBJ_DIR ?= obj_dir
VFLAGS ?= --binary --timing --assert -j 0
PASS_TEXT ?= Simulation finished: PASS

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)
